/* common/fetch_pkg.sv */
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Constants
    //////////////////////////////////////////////////////////////////////

    // Fetch PC after reset
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // Fetch address error, bit 7 is the write enable, low bits code 8
    localparam logic [7:0] ECODE_ADEF = 8'h88;

    // Branch target buffer geometry
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    // Tag covers the PC above index and byte offset
    localparam int BTB_TAG_W   = 30 - BTB_IDX_W;

    // Instruction memory depth in words
    localparam int IMEM_WORDS = 1024;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);

    // Fetch queue
    localparam int FQ_DEPTH = 8;
    localparam int FQ_AW    = $clog2(FQ_DEPTH);

    // Major opcodes of the direct jumps
    localparam logic [5:0] OP_B  = 6'b010100;
    localparam logic [5:0] OP_BL = 6'b010101;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Winning next-PC source in IF1, highest priority first
    typedef enum logic [2:0] {
        SRC_ERA,
        SRC_EENTRY,
        SRC_CSR,
        SRC_CACOP,
        SRC_MEM,
        SRC_PREDEC,
        SRC_HOLD,
        SRC_PREDICT
    } redirect_src_e;

    // Predecoded instruction class
    typedef enum logic [1:0] {
        JK_NONE,
        JK_B,
        JK_BL
    } jump_kind_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    // IF1 to IF2 request
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] pred_pc;
        logic [7:0]  ecode;
    } fetch_req_t;

    // One fetched instruction in the queue
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [7:0]  ecode;
        jump_kind_e  kind;
    } fetch_entry_t;

    // Buffer training write
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
    } btb_update_t;

endpackage

/* rtl/pc_select.sv */
module pc_select (
    input  logic                  clk,
    input  logic                  rstn,
    input  fetch_pkg::redirect_t  era_redir,
    input  fetch_pkg::redirect_t  eentry_redir,
    input  fetch_pkg::redirect_t  csr_redir,
    input  fetch_pkg::redirect_t  cacop_redir,
    input  fetch_pkg::redirect_t  mem_redir,
    input  fetch_pkg::redirect_t  predec_redir,
    input  logic [31:0]           pc_predict,
    input  logic                  stall_icache,
    input  logic                  stall_full,
    output logic [31:0]           pc_if1,
    output fetch_pkg::fetch_req_t req
);

    fetch_pkg::redirect_src_e src;
    logic [31:0]              pc_next;
    logic                     stall;
    logic                     any_redir;
    // Low only in the first cycle after reset
    logic                     run_q;

    assign stall = stall_icache | stall_full;

    // Predecoder correction counts as a redirect too
    assign any_redir = era_redir.valid | eentry_redir.valid | csr_redir.valid |
                       cacop_redir.valid | mem_redir.valid | predec_redir.valid;

    //////////////////////////////////////////////////////////////////////
    // Next-PC priority
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (era_redir.valid) begin
            src = fetch_pkg::SRC_ERA;
        end else if (eentry_redir.valid) begin
            src = fetch_pkg::SRC_EENTRY;
        end else if (csr_redir.valid) begin
            src = fetch_pkg::SRC_CSR;
        end else if (cacop_redir.valid) begin
            src = fetch_pkg::SRC_CACOP;
        end else if (mem_redir.valid) begin
            src = fetch_pkg::SRC_MEM;
        end else if (predec_redir.valid) begin
            src = fetch_pkg::SRC_PREDEC;
        end else if (stall || !run_q) begin
            // Reset PC is not yet fetched in the first cycle
            src = fetch_pkg::SRC_HOLD;
        end else begin
            src = fetch_pkg::SRC_PREDICT;
        end
    end

    always_comb begin
        case (src)
            fetch_pkg::SRC_ERA:    pc_next = era_redir.pc;
            fetch_pkg::SRC_EENTRY: pc_next = eentry_redir.pc;
            fetch_pkg::SRC_CSR:    pc_next = csr_redir.pc;
            fetch_pkg::SRC_CACOP:  pc_next = cacop_redir.pc;
            fetch_pkg::SRC_MEM:    pc_next = mem_redir.pc;
            fetch_pkg::SRC_PREDEC: pc_next = predec_redir.pc;
            fetch_pkg::SRC_HOLD:   pc_next = pc_if1;
            default:               pc_next = pc_predict;
        endcase
    end

    // PC register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_if1 <= fetch_pkg::RESET_PC;
            run_q  <= 1'b0;
        end else begin
            pc_if1 <= pc_next;
            run_q  <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request to IF2
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Killed by any redirect or stall
        req.valid   = run_q & ~stall & ~any_redir;
        req.pc      = pc_if1;
        req.pred_pc = pc_predict;
        // Misaligned fetch address
        req.ecode   = (pc_if1[1:0] != 2'b00) ? fetch_pkg::ECODE_ADEF : 8'h00;
    end

endmodule

/* rtl/next_pc_predict.sv */
module next_pc_predict (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [31:0]            pc_if1,
    input  fetch_pkg::btb_update_t update,
    output logic [31:0]            pc_predict
);

    // Table storage
    logic [fetch_pkg::BTB_ENTRIES-1:0] btb_valid;
    logic [fetch_pkg::BTB_TAG_W-1:0]   btb_tag    [fetch_pkg::BTB_ENTRIES];
    logic [31:0]                       btb_target [fetch_pkg::BTB_ENTRIES];

    // Lookup and update fields
    logic [fetch_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] rd_tag;
    logic [fetch_pkg::BTB_IDX_W-1:0] wr_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] wr_tag;
    logic                            hit;

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    // Word index just above the byte offset
    assign rd_idx = pc_if1[fetch_pkg::BTB_IDX_W+1:2];
    assign rd_tag = pc_if1[31:fetch_pkg::BTB_IDX_W+2];

    assign hit = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);

    // Fall through to the next word on a miss
    assign pc_predict = hit ? btb_target[rd_idx] : pc_if1 + 32'd4;

    //////////////////////////////////////////////////////////////////////
    // Training
    //////////////////////////////////////////////////////////////////////

    assign wr_idx = update.pc[fetch_pkg::BTB_IDX_W+1:2];
    assign wr_tag = update.pc[31:fetch_pkg::BTB_IDX_W+2];

    // Valid bits start cleared
    always_ff @(posedge clk) begin
        if (!rstn) begin
            btb_valid <= '0;
        end else if (update.valid) begin
            btb_valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and target, replaced on every update
    always_ff @(posedge clk) begin
        if (update.valid) begin
            btb_tag[wr_idx]    <= wr_tag;
            btb_target[wr_idx] <= update.target;
        end
    end

endmodule

/* rtl/inst_mem.sv */
module inst_mem (
    input  logic                          clk,
    input  logic [31:0]                   addr,
    input  logic                          we,
    input  logic [fetch_pkg::IMEM_AW-1:0] waddr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata
);

    // Word storage
    logic [31:0] mem [fetch_pkg::IMEM_WORDS];

    // Read word index, byte offset dropped
    logic [fetch_pkg::IMEM_AW-1:0] raddr;

    assign raddr = addr[fetch_pkg::IMEM_AW+1:2];

    //////////////////////////////////////////////////////////////////////
    // Program load port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registered read
    //////////////////////////////////////////////////////////////////////

    // Word for the IF1 PC shows up in IF2
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* rtl/fetch_predecode.sv */
module fetch_predecode (
    input  logic                    clk,
    input  logic                    rstn,
    input  fetch_pkg::fetch_req_t   req,
    input  logic [31:0]             rdata,
    input  logic                    stall_full,
    input  logic                    flush,
    output fetch_pkg::redirect_t    predec_redir,
    output fetch_pkg::btb_update_t  btb_update,
    output logic                    enq,
    output fetch_pkg::fetch_entry_t enq_entry
);

    // IF2 register
    logic        if2_valid;
    logic [31:0] if2_pc;
    logic [31:0] if2_pred;
    logic [7:0]  if2_ecode;

    // Predecode
    logic [5:0]            opcode;
    logic [25:0]           offs26;
    fetch_pkg::jump_kind_e kind;
    logic [31:0]           jump_target;
    logic [31:0]           next_pc;
    logic                  live;

    //////////////////////////////////////////////////////////////////////
    // IF2 stage register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            if2_valid <= 1'b0;
        end else if (flush || stall_full) begin
            if2_valid <= 1'b0;
        end else begin
            if2_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_full) begin
            if2_pc    <= req.pc;
            if2_pred  <= req.pred_pc;
            if2_ecode <= req.ecode;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Direct-jump predecode
    //////////////////////////////////////////////////////////////////////

    assign opcode = rdata[31:26];
    // offs[15:0] in bits 25:10, offs[25:16] in bits 9:0
    assign offs26 = {rdata[9:0], rdata[25:10]};

    always_comb begin
        if (if2_ecode != 8'h00) begin
            // Faulting fetch is never a jump
            kind = fetch_pkg::JK_NONE;
        end else if (opcode == fetch_pkg::OP_B) begin
            kind = fetch_pkg::JK_B;
        end else if (opcode == fetch_pkg::OP_BL) begin
            kind = fetch_pkg::JK_BL;
        end else begin
            kind = fetch_pkg::JK_NONE;
        end
    end

    assign jump_target = if2_pc + {{4{offs26[25]}}, offs26, 2'b00};
    assign next_pc = (kind != fetch_pkg::JK_NONE) ? jump_target : if2_pc + 32'd4;

    // Outside redirect drops the IF2 item at once
    assign live = if2_valid & ~flush;

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    // Queue always has a slot for the IF2 item
    assign enq = live;

    always_comb begin
        enq_entry.pc    = if2_pc;
        enq_entry.inst  = rdata;
        enq_entry.ecode = if2_ecode;
        enq_entry.kind  = kind;
    end

    // Wrong prediction, refetch from the correct PC
    always_comb begin
        predec_redir.valid = live & (next_pc != if2_pred);
        predec_redir.pc    = next_pc;
    end

    // Every jump trains its buffer entry
    always_comb begin
        btb_update.valid  = live & (kind != fetch_pkg::JK_NONE);
        btb_update.pc     = if2_pc;
        btb_update.target = jump_target;
    end

endmodule

/* rtl/fetch_queue.sv */
module fetch_queue (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    enq,
    input  fetch_pkg::fetch_entry_t enq_entry,
    input  logic                    deq,
    input  logic                    flush,
    output fetch_pkg::fetch_entry_t fq_out,
    output logic                    fq_valid,
    output logic                    stall_full
);

    // Entry storage
    fetch_pkg::fetch_entry_t fq_mem [fetch_pkg::FQ_DEPTH];

    // Pointers wrap with the power-of-two depth
    logic [fetch_pkg::FQ_AW-1:0] wr_ptr;
    logic [fetch_pkg::FQ_AW-1:0] rd_ptr;
    logic [fetch_pkg::FQ_AW:0]   count;
    logic                        full;
    logic                        push;
    logic                        pop;

    assign full = (count == (fetch_pkg::FQ_AW+1)'(fetch_pkg::FQ_DEPTH));

    // Flush wins over both ends
    assign push = enq & ~flush & ~full;
    assign pop  = deq & fq_valid & ~flush;

    //////////////////////////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////////////////////////

    assign fq_valid = (count != '0);

    // One slot kept free for the item already in IF2
    assign stall_full = (count >= (fetch_pkg::FQ_AW+1)'(fetch_pkg::FQ_DEPTH - 1));

    // Head entry
    assign fq_out = fq_mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Entry write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            fq_mem[wr_ptr] <= enq_entry;
        end
    end

endmodule

/* rtl/fetch_top.sv */
module fetch_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  fetch_pkg::redirect_t          era_redir,
    input  fetch_pkg::redirect_t          eentry_redir,
    input  fetch_pkg::redirect_t          csr_redir,
    input  fetch_pkg::redirect_t          cacop_redir,
    input  fetch_pkg::redirect_t          mem_redir,
    input  logic                          stall_icache,
    input  logic                          deq,
    input  logic                          imem_we,
    input  logic [fetch_pkg::IMEM_AW-1:0] imem_waddr,
    input  logic [31:0]                   imem_wdata,
    output fetch_pkg::fetch_entry_t       fq_out,
    output logic                          fq_valid
);

    // IF1
    logic [31:0]             pc_if1;
    logic [31:0]             pc_predict;
    fetch_pkg::fetch_req_t   req;

    // IF2
    logic [31:0]             imem_rdata;
    fetch_pkg::redirect_t    predec_redir;
    fetch_pkg::btb_update_t  btb_update;
    logic                    enq;
    fetch_pkg::fetch_entry_t enq_entry;

    // Queue back-pressure and flush
    logic                    stall_full;
    logic                    flush;

    // Any outside redirect empties IF2 and the queue
    assign flush = era_redir.valid | eentry_redir.valid | csr_redir.valid |
                   cacop_redir.valid | mem_redir.valid;

    //////////////////////////////////////////////////////////////////////
    // IF1
    //////////////////////////////////////////////////////////////////////

    pc_select u_pc_select (
        .clk          (clk),
        .rstn         (rstn),
        .era_redir    (era_redir),
        .eentry_redir (eentry_redir),
        .csr_redir    (csr_redir),
        .cacop_redir  (cacop_redir),
        .mem_redir    (mem_redir),
        .predec_redir (predec_redir),
        .pc_predict   (pc_predict),
        .stall_icache (stall_icache),
        .stall_full   (stall_full),
        .pc_if1       (pc_if1),
        .req          (req)
    );

    next_pc_predict u_next_pc_predict (
        .clk        (clk),
        .rstn       (rstn),
        .pc_if1     (pc_if1),
        .update     (btb_update),
        .pc_predict (pc_predict)
    );

    inst_mem u_inst_mem (
        .clk   (clk),
        .addr  (pc_if1),
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata),
        .rdata (imem_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // IF2 and queue
    //////////////////////////////////////////////////////////////////////

    fetch_predecode u_fetch_predecode (
        .clk          (clk),
        .rstn         (rstn),
        .req          (req),
        .rdata        (imem_rdata),
        .stall_full   (stall_full),
        .flush        (flush),
        .predec_redir (predec_redir),
        .btb_update   (btb_update),
        .enq          (enq),
        .enq_entry    (enq_entry)
    );

    fetch_queue u_fetch_queue (
        .clk        (clk),
        .rstn       (rstn),
        .enq        (enq),
        .enq_entry  (enq_entry),
        .deq        (deq),
        .flush      (flush),
        .fq_out     (fq_out),
        .fq_valid   (fq_valid),
        .stall_full (stall_full)
    );

endmodule

/* tb/fetch_clock.sv */
module fetch_clock (
    output logic clk,
    output logic rstn
);

    // Period 20, low phase first
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held over the first 16 rising edges
    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

/* tb/fetch_props.sv */
module fetch_props (
    input logic                        clk,
    input logic                        rstn,
    input logic                        fq_valid,
    input logic                        enq,
    input logic                        predec_valid,
    input logic                        btb_upd_valid,
    input logic                        flush,
    input logic                        stall_icache,
    input logic                        stall_full,
    input logic [31:0]                 pc_if1,
    input logic [fetch_pkg::FQ_AW:0]   fq_count
);

    // Count of failed assertions
    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // Reset
    //////////////////////////////////////////////////////////////////////

    // Every output quiet from the second reset edge on
    property quiet_in_reset;
        @(posedge clk) (rstn === 1'b0 && $past(rstn) === 1'b0) |->
            !fq_valid && !enq && !predec_valid && !btb_upd_valid;
    endproperty

    assert property (quiet_in_reset)
        else begin
            $error("queue or redirect output active during reset");
            fail_count++;
        end

    //////////////////////////////////////////////////////////////////////
    // Queue and IF1
    //////////////////////////////////////////////////////////////////////

    // IF2 item must always find a free slot
    property enq_has_room;
        @(posedge clk) disable iff (!rstn)
            enq |-> fq_count != (fetch_pkg::FQ_AW+1)'(fetch_pkg::FQ_DEPTH);
    endproperty

    assert property (enq_has_room)
        else begin
            $error("enqueue while the fetch queue is full");
            fail_count++;
        end

    // Stall alone holds the PC
    property pc_hold_on_stall;
        @(posedge clk) disable iff (!rstn)
            (stall_icache || stall_full) && !flush && !predec_valid |=> $stable(pc_if1);
    endproperty

    assert property (pc_hold_on_stall)
        else begin
            $error("pc_if1 moved during a stall without a redirect");
            fail_count++;
        end

endmodule

/* tb/fetch_tb.sv */
module fetch_tb;

    // Program fits the 16 write cycles of reset
    localparam int PROG_WORDS      = 16;
    localparam int PHASE_CYCLES    = 100;
    localparam int FLOW_CYCLES     = 140;
    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = PROG_WORDS * 40;

    logic                          clk;
    logic                          rstn;
    fetch_pkg::redirect_t          era_redir;
    fetch_pkg::redirect_t          eentry_redir;
    fetch_pkg::redirect_t          csr_redir;
    fetch_pkg::redirect_t          cacop_redir;
    fetch_pkg::redirect_t          mem_redir;
    logic                          stall_icache;
    logic                          deq;
    logic                          imem_we;
    logic [fetch_pkg::IMEM_AW-1:0] imem_waddr;
    logic [31:0]                   imem_wdata;
    fetch_pkg::fetch_entry_t       fq_out;
    logic                          fq_valid;

    // Model state
    logic [31:0] lfsr;
    logic [31:0] prog [PROG_WORDS];
    logic [31:0] exp_pc;
    logic        flushed_prev;
    logic        after_redir;
    int          value_errors;
    int          other_errors;
    int          pops;
    int          mis_pops;
    int          redirects;
    int          redir_pops;

    fetch_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    fetch_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .era_redir    (era_redir),
        .eentry_redir (eentry_redir),
        .csr_redir    (csr_redir),
        .cacop_redir  (cacop_redir),
        .mem_redir    (mem_redir),
        .stall_icache (stall_icache),
        .deq          (deq),
        .imem_we      (imem_we),
        .imem_waddr   (imem_waddr),
        .imem_wdata   (imem_wdata),
        .fq_out       (fq_out),
        .fq_valid     (fq_valid)
    );

    bind fetch_top fetch_props u_props (
        .clk           (clk),
        .rstn          (rstn),
        .fq_valid      (fq_valid),
        .enq           (enq),
        .predec_valid  (predec_redir.valid),
        .btb_upd_valid (btb_update.valid),
        .flush         (flush),
        .stall_icache  (stall_icache),
        .stall_full    (stall_full),
        .pc_if1        (pc_if1),
        .fq_count      (u_fetch_queue.count)
    );

    //////////////////////////////////////////////////////////////////////
    // Random bits and program model
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // offs[15:0] in bits 25:10, offs[25:16] in bits 9:0
    function automatic logic [31:0] make_jump(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    // Only aligned B and BL jump and the rest go to pc+4
    function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc, input logic [31:0] inst);
        logic [25:0] offs;
        offs = {inst[9:0], inst[25:10]};
        if (pc[1:0] != 2'b00) begin
            return pc + 32'd4;
        end
        if (inst[31:26] == 6'b010100 || inst[31:26] == 6'b010101) begin
            return pc + {{4{offs[25]}}, offs, 2'b00};
        end
        return pc + 32'd4;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            value_errors++;
        end
    endtask

    task automatic build_program();
        logic [31:0] w;
        logic [31:0] r;
        int          off;
        for (int i = 0; i < PROG_WORDS; i++) begin
            take_bits(32, w);
            take_bits(2, r);
            // About a quarter jump and the last word always jumps back
            if (r[1:0] == 2'b00 || i == PROG_WORDS - 1) begin
                take_bits(5, r);
                off = int'(r[3:0]) - i;
                prog[i] = make_jump(r[4] ? 6'b010101 : 6'b010100, 26'(off));
            end else begin
                // Keep plain words off the jump opcodes
                if (w[31:27] == 5'b01010) begin
                    w[31] = 1'b1;
                end
                prog[i] = w;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One cycle of stimulus and checking
    //////////////////////////////////////////////////////////////////////

    task automatic run_cycle(input bit redir_on, input bit misalign_on,
                             input bit busy_on, input bit hold_deq);
        logic [31:0] r;
        logic [31:0] tgt [5];
        logic [4:0]  mask;
        logic [31:0] word;
        logic [7:0]  exp_ecode;
        logic [1:0]  exp_kind;
        logic        deq_now;
        logic        stall_now;
        @(negedge clk);
        // Flush leaves the queue empty for at least a cycle
        if (flushed_prev) begin
            assert (!fq_valid) else begin
                $display("fq_valid still high in the cycle after a flush");
                other_errors++;
            end
        end
        // Candidate targets inside the program window
        for (int j = 0; j < 5; j++) begin
            take_bits(4, r);
            tgt[j] = {fetch_pkg::RESET_PC[31:6], r[3:0], 2'b00};
            if (misalign_on) begin
                take_bits(2, r);
                tgt[j][1:0] = r[1:0];
            end
        end
        mask = 5'b00000;
        if (exp_pc[31:6] != fetch_pkg::RESET_PC[31:6]) begin
            // Steer a misaligned flow that ran off the program back in
            mask        = 5'b00001;
            tgt[0][1:0] = 2'b00;
        end else if (redir_on) begin
            take_bits(4, r);
            if (r[3:0] == 4'd0) begin
                take_bits(5, r);
                mask = (r[4:0] == 5'd0) ? 5'b00001 : r[4:0];
            end
        end
        deq_now   = 1'b1;
        stall_now = 1'b0;
        if (busy_on) begin
            take_bits(1, r);
            deq_now = r[0] & ~hold_deq;
            take_bits(2, r);
            stall_now = (r[1:0] == 2'b00);
        end
        if (mask != 5'b00000) begin
            // Bit 4 is the exception return and the last hit wins
            for (int j = 0; j < 5; j++) begin
                if (mask[j]) begin
                    exp_pc = tgt[j];
                end
            end
            redirects++;
            flushed_prev = 1'b1;
            after_redir  = 1'b1;
        end else begin
            flushed_prev = 1'b0;
            if (deq_now && fq_valid) begin
                word      = prog[exp_pc[5:2]];
                exp_ecode = (exp_pc[1:0] != 2'b00) ? 8'h88 : 8'h00;
                if (exp_ecode != 8'h00) begin
                    exp_kind = fetch_pkg::JK_NONE;
                    mis_pops++;
                end else if (word[31:26] == 6'b010100) begin
                    exp_kind = fetch_pkg::JK_B;
                end else if (word[31:26] == 6'b010101) begin
                    exp_kind = fetch_pkg::JK_BL;
                end else begin
                    exp_kind = fetch_pkg::JK_NONE;
                end
                check_field("fq_out.pc", fq_out.pc, exp_pc);
                check_field("fq_out.inst", fq_out.inst, word);
                check_field("fq_out.ecode", 32'(fq_out.ecode), 32'(exp_ecode));
                check_field("fq_out.kind", 32'(fq_out.kind), 32'(exp_kind));
                pops++;
                // First entry after a redirect sits at its target
                if (after_redir) begin
                    redir_pops++;
                    after_redir = 1'b0;
                end
                exp_pc = next_fetch_pc(exp_pc, word);
            end
        end
        era_redir.valid    = mask[4];
        era_redir.pc       = tgt[4];
        eentry_redir.valid = mask[3];
        eentry_redir.pc    = tgt[3];
        csr_redir.valid    = mask[2];
        csr_redir.pc       = tgt[2];
        cacop_redir.valid  = mask[1];
        cacop_redir.pc     = tgt[1];
        mem_redir.valid    = mask[0];
        mem_redir.pc       = tgt[0];
        deq                = deq_now;
        stall_icache       = stall_now;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        lfsr         = 32'h423dee60;
        value_errors = 0;
        other_errors = 0;
        pops         = 0;
        mis_pops     = 0;
        redirects    = 0;
        redir_pops   = 0;
        flushed_prev = 1'b0;
        after_redir  = 1'b0;
        exp_pc       = fetch_pkg::RESET_PC;
        era_redir    = '0;
        eentry_redir = '0;
        csr_redir    = '0;
        cacop_redir  = '0;
        mem_redir    = '0;
        stall_icache = 1'b0;
        deq          = 1'b0;
        build_program();
        // First word goes in before the first edge
        imem_we    = 1'b1;
        imem_waddr = '0;
        imem_wdata = prog[0];
        for (int i = 1; i < PROG_WORDS; i++) begin
            @(negedge clk);
            imem_waddr = i[fetch_pkg::IMEM_AW-1:0];
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        while (!rstn) begin
            @(negedge clk);
        end
        // Reset PC first and then plain and jumping flow
        repeat (PHASE_CYCLES) run_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        assert (pops > 0) else begin
            $display("no entry was popped in plain flow");
            other_errors++;
        end
        // Aligned outside redirects, sometimes several at once
        repeat (PHASE_CYCLES) run_cycle(1'b1, 1'b0, 1'b0, 1'b0);
        assert (redir_pops > 0) else begin
            $display("no entry was popped at a redirect target");
            other_errors++;
        end
        // Misaligned targets
        repeat (PHASE_CYCLES) run_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        assert (mis_pops > 0) else begin
            $display("no misaligned entry was popped");
            other_errors++;
        end
        // Stalls, random pops and a stretch with no pops
        for (int c = 0; c < FLOW_CYCLES; c++) begin
            run_cycle(1'b1, 1'b1, 1'b1, c >= 20 && c < 45);
        end
        @(negedge clk);
        deq          = 1'b0;
        stall_icache = 1'b0;
        era_redir    = '0;
        eentry_redir = '0;
        csr_redir    = '0;
        cacop_redir  = '0;
        mem_redir    = '0;
        $display("Errors: %0d wrong values, %0d other failures, %0d assertion failures (%0d pops)",
                 value_errors, other_errors, uut.u_props.fail_count, pops);
        if (value_errors == 0 && other_errors == 0 && uut.u_props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence ended");
        $display("Test failed");
        $finish;
    end

endmodule

/* list.f */
common/fetch_pkg.sv
rtl/pc_select.sv
rtl/next_pc_predict.sv
rtl/inst_mem.sv
rtl/fetch_predecode.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
tb/fetch_clock.sv
tb/fetch_props.sv
tb/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
		-Mdir obj_dir -f list.f

run: compile
	./obj_dir/Vfetch_tb | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
